// ==== wb_pkg.sv ====
package wb_pkg;

  // Host command opcodes.
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } wb_op_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUS  = 2'd1,
    ST_RESP = 2'd2
  } bridge_state_e;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = 4;

  // Region codes held in the top address byte.
  localparam logic [7:0] SLV_SRAM  = 8'h00;
  localparam logic [7:0] SLV_TIMER = 8'h01;
  localparam logic [7:0] SLV_GPIO  = 8'h02;
  localparam logic [7:0] SLV_IRQ   = 8'hFF;

  localparam int CMD_DEPTH   = 4;   // Equal to the credits the sender starts with.
  localparam int RSP_CREDITS = 2;
  localparam int SRAM_WORDS  = 256;

  localparam logic [1:0] TMR_CTRL   = 2'd0;
  localparam logic [1:0] TMR_LOAD   = 2'd1;
  localparam logic [1:0] TMR_COUNT  = 2'd2;
  localparam logic [1:0] TMR_STATUS = 2'd3;

  localparam logic [1:0] GPIO_OUT    = 2'd0;
  localparam logic [1:0] GPIO_IN     = 2'd1;
  localparam logic [1:0] GPIO_MASK   = 2'd2;
  localparam logic [1:0] GPIO_STATUS = 2'd3;

  localparam int GPIO_W = 8;

endpackage

// ==== wb_interconnect.sv ====
module wb_interconnect (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_m_cyc,
  input  logic                      i_m_stb,
  input  logic                      i_m_we,
  input  logic [wb_pkg::SEL_W-1:0]  i_m_sel,
  input  logic [wb_pkg::ADDR_W-1:0] i_m_adr,
  input  logic [wb_pkg::DATA_W-1:0] i_m_dat,
  output logic [wb_pkg::DATA_W-1:0] o_m_dat,
  output logic                      o_m_ack,
  output logic                      o_m_err,
  output logic                      o_m_int,
  output logic                      o_s0_cyc, o_s0_stb, o_s0_we,
  output logic [wb_pkg::SEL_W-1:0]  o_s0_sel,
  output logic [wb_pkg::ADDR_W-1:0] o_s0_adr,
  output logic [wb_pkg::DATA_W-1:0] o_s0_dat,
  input  logic                      i_s0_ack, i_s0_int,
  input  logic [wb_pkg::DATA_W-1:0] i_s0_dat,
  output logic                      o_s1_cyc, o_s1_stb, o_s1_we,
  output logic [wb_pkg::SEL_W-1:0]  o_s1_sel,
  output logic [wb_pkg::ADDR_W-1:0] o_s1_adr,
  output logic [wb_pkg::DATA_W-1:0] o_s1_dat,
  input  logic                      i_s1_ack, i_s1_int,
  input  logic [wb_pkg::DATA_W-1:0] i_s1_dat,
  output logic                      o_s2_cyc, o_s2_stb, o_s2_we,
  output logic [wb_pkg::SEL_W-1:0]  o_s2_sel,
  output logic [wb_pkg::ADDR_W-1:0] o_s2_adr,
  output logic [wb_pkg::DATA_W-1:0] o_s2_dat,
  input  logic                      i_s2_ack, i_s2_int,
  input  logic [wb_pkg::DATA_W-1:0] i_s2_dat
);
  import wb_pkg::*;

  logic [7:0]        region;
  logic              hit_sram;
  logic              hit_timer;
  logic              hit_gpio;
  logic              req;
  logic              local_done;
  logic [ADDR_W-1:0] slv_adr;
  logic [DATA_W-1:0] irq_word;

  assign region    = i_m_adr[ADDR_W-1:ADDR_W-8];
  assign hit_sram  = (region == SLV_SRAM);
  assign hit_timer = (region == SLV_TIMER);
  assign hit_gpio  = (region == SLV_GPIO);
  assign req       = i_m_cyc & i_m_stb;
  assign slv_adr   = {8'h00, i_m_adr[ADDR_W-9:0]};  // Slaves see only their offset.
  assign irq_word  = {{(DATA_W-3){1'b0}}, i_s2_int, i_s1_int, i_s0_int};
  assign o_m_int   = i_s0_int | i_s1_int | i_s2_int;

  assign o_s0_cyc = hit_sram & i_m_cyc;
  assign o_s0_stb = hit_sram & i_m_stb;
  assign o_s0_we  = hit_sram & i_m_we;
  assign o_s0_sel = hit_sram ? i_m_sel : '0;
  assign o_s0_adr = hit_sram ? slv_adr : '0;
  assign o_s0_dat = hit_sram ? i_m_dat : '0;
  assign o_s1_cyc = hit_timer & i_m_cyc;
  assign o_s1_stb = hit_timer & i_m_stb;
  assign o_s1_we  = hit_timer & i_m_we;
  assign o_s1_sel = hit_timer ? i_m_sel : '0;
  assign o_s1_adr = hit_timer ? slv_adr : '0;
  assign o_s1_dat = hit_timer ? i_m_dat : '0;
  assign o_s2_cyc = hit_gpio & i_m_cyc;
  assign o_s2_stb = hit_gpio & i_m_stb;
  assign o_s2_we  = hit_gpio & i_m_we;
  assign o_s2_sel = hit_gpio ? i_m_sel : '0;
  assign o_s2_adr = hit_gpio ? slv_adr : '0;
  assign o_s2_dat = hit_gpio ? i_m_dat : '0;

  // A locally answered cycle gets one ack or err pulse even if strobe is held.
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      local_done <= 1'b0;
    end else begin
      local_done <= req & ~(hit_sram | hit_timer | hit_gpio);
    end
  end

  always_comb begin
    o_m_dat = '0;
    o_m_ack = 1'b0;
    o_m_err = 1'b0;
    case (region)
      SLV_SRAM: begin
        o_m_dat = i_s0_dat;
        o_m_ack = i_s0_ack;
      end
      SLV_TIMER: begin
        o_m_dat = i_s1_dat;
        o_m_ack = i_s1_ack;
      end
      SLV_GPIO: begin
        o_m_dat = i_s2_dat;
        o_m_ack = i_s2_ack;
      end
      SLV_IRQ: begin
        o_m_dat = irq_word;
        o_m_ack = req & ~local_done;
      end
      default: o_m_err = req & ~local_done;  // Unmapped region.
    endcase
  end

endmodule

// ==== wb_host_bridge.sv ====
module wb_host_bridge (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_cmd_valid,
  input  wb_pkg::wb_op_e            i_cmd_op,
  input  logic [wb_pkg::ADDR_W-1:0] i_cmd_adr,
  input  logic [wb_pkg::SEL_W-1:0]  i_cmd_sel,
  input  logic [wb_pkg::DATA_W-1:0] i_cmd_dat,
  output logic                      o_cmd_credit,
  input  logic                      i_rsp_credit,
  output logic                      o_rsp_valid,
  output logic [wb_pkg::DATA_W-1:0] o_rsp_dat,
  output logic                      o_rsp_err,
  output logic                      o_m_cyc,
  output logic                      o_m_stb,
  output logic                      o_m_we,
  output logic [wb_pkg::SEL_W-1:0]  o_m_sel,
  output logic [wb_pkg::ADDR_W-1:0] o_m_adr,
  output logic [wb_pkg::DATA_W-1:0] o_m_dat,
  input  logic                      i_m_ack,
  input  logic                      i_m_err,
  input  logic [wb_pkg::DATA_W-1:0] i_m_dat
);
  import wb_pkg::*;

  wb_op_e                           q_op  [CMD_DEPTH];
  logic [ADDR_W-1:0]                q_adr [CMD_DEPTH];
  logic [SEL_W-1:0]                 q_sel [CMD_DEPTH];
  logic [DATA_W-1:0]                q_dat [CMD_DEPTH];
  logic [$clog2(CMD_DEPTH)-1:0]     wr_ptr;
  logic [$clog2(CMD_DEPTH)-1:0]     rd_ptr;
  logic [$clog2(CMD_DEPTH+1)-1:0]   q_count;
  logic [$clog2(RSP_CREDITS+1)-1:0] rsp_credits;
  bridge_state_e                    state;
  logic                             push;
  logic                             pop;

  // The sender never overruns its credits, so the full check only guards the pointers.
  assign push = i_cmd_valid & (q_count != ($clog2(CMD_DEPTH+1))'(CMD_DEPTH));
  assign pop  = (state == ST_IDLE) & (q_count != '0) & (rsp_credits != '0);

  assign o_cmd_credit = pop;  // Queue slot freed.
  assign o_m_cyc      = (state == ST_BUS);
  assign o_m_stb      = (state == ST_BUS);
  assign o_rsp_valid  = (state == ST_RESP);

  always_ff @(posedge clk) begin
    if (push) begin
      q_op[wr_ptr]  <= i_cmd_op;
      q_adr[wr_ptr] <= i_cmd_adr;
      q_sel[wr_ptr] <= i_cmd_sel;
      q_dat[wr_ptr] <= i_cmd_dat;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      q_count     <= '0;
      rsp_credits <= ($clog2(RSP_CREDITS+1))'(RSP_CREDITS);
      state       <= ST_IDLE;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
      // A credit is spent on each response and returned by the host.
      case ({i_rsp_credit, o_rsp_valid})
        2'b10:   rsp_credits <= rsp_credits + 1'b1;
        2'b01:   rsp_credits <= rsp_credits - 1'b1;
        default: rsp_credits <= rsp_credits;
      endcase
      case (state)
        ST_IDLE: begin
          if (pop) begin
            state <= ST_BUS;
          end
        end
        ST_BUS: begin
          if (i_m_ack | i_m_err) begin
            state <= ST_RESP;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      o_m_we  <= (q_op[rd_ptr] == OP_WRITE);
      o_m_sel <= q_sel[rd_ptr];
      o_m_adr <= q_adr[rd_ptr];
      o_m_dat <= q_dat[rd_ptr];
    end
    if ((state == ST_BUS) && (i_m_ack || i_m_err)) begin
      o_rsp_dat <= i_m_dat;
      o_rsp_err <= i_m_err;
    end
  end

endmodule

// ==== wb_sram.sv ====
module wb_sram (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_cyc,
  input  logic                      i_stb,
  input  logic                      i_we,
  input  logic [wb_pkg::SEL_W-1:0]  i_sel,
  input  logic [wb_pkg::ADDR_W-1:0] i_adr,
  input  logic [wb_pkg::DATA_W-1:0] i_dat,
  output logic                      o_ack,
  output logic [wb_pkg::DATA_W-1:0] o_dat,
  output logic                      o_int
);
  import wb_pkg::*;

  logic [DATA_W-1:0]             mem [SRAM_WORDS];
  logic [$clog2(SRAM_WORDS)-1:0] word_idx;
  logic                          access;

  assign word_idx = i_adr[$clog2(SRAM_WORDS)+1:2];
  assign access   = i_cyc & i_stb & ~o_ack;  // Once per cycle, on the first strobe.
  assign o_int    = 1'b0;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (i_we) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (i_sel[b]) begin
            mem[word_idx][8*b +: 8] <= i_dat[8*b +: 8];
          end
        end
      end
      o_dat <= mem[word_idx];
    end
  end

endmodule

// ==== wb_timer.sv ====
module wb_timer (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_cyc,
  input  logic                      i_stb,
  input  logic                      i_we,
  input  logic [wb_pkg::SEL_W-1:0]  i_sel,
  input  logic [wb_pkg::ADDR_W-1:0] i_adr,
  input  logic [wb_pkg::DATA_W-1:0] i_dat,
  output logic                      o_ack,
  output logic [wb_pkg::DATA_W-1:0] o_dat,
  output logic                      o_int
);
  import wb_pkg::*;

  logic [1:0]        ctrl_q;  // Bit 0 runs the counter, bit 1 enables the interrupt.
  logic [DATA_W-1:0] load_q;
  logic [DATA_W-1:0] count_q;
  logic              status_q;
  logic              access;
  logic              wr;
  logic [1:0]        offset;
  logic [DATA_W-1:0] wmask;
  logic [DATA_W-1:0] load_next;

  assign access    = i_cyc & i_stb & ~o_ack;
  assign wr        = access & i_we;
  assign offset    = i_adr[3:2];
  assign load_next = (load_q & ~wmask) | (i_dat & wmask);
  assign o_int     = status_q & ctrl_q[1];

  always_comb begin
    for (int b = 0; b < SEL_W; b++) begin
      wmask[8*b +: 8] = {8{i_sel[b]}};
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ack    <= 1'b0;
      ctrl_q   <= '0;
      load_q   <= '0;
      count_q  <= '0;
      status_q <= 1'b0;
    end else begin
      o_ack <= access;
      if (ctrl_q[0]) begin
        count_q <= (count_q == '0) ? load_q : count_q - 1'b1;
      end
      if (wr) begin
        case (offset)
          TMR_CTRL: begin
            if (i_sel[0]) begin
              ctrl_q <= i_dat[1:0];
            end
          end
          TMR_LOAD: begin
            load_q  <= load_next;
            count_q <= load_next;  // A new reload value restarts the count.
          end
          TMR_STATUS: begin
            if (i_sel[0] && i_dat[0]) begin
              status_q <= 1'b0;
            end
          end
          default: ;
        endcase
      end
      // An expiry in the same cycle as a clear wins, so no event is lost.
      if (ctrl_q[0] && (count_q == '0)) begin
        status_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (offset)
        TMR_CTRL:  o_dat <= {{(DATA_W-2){1'b0}}, ctrl_q};
        TMR_LOAD:  o_dat <= load_q;
        TMR_COUNT: o_dat <= count_q;
        default:   o_dat <= {{(DATA_W-1){1'b0}}, status_q};
      endcase
    end
  end

endmodule

// ==== wb_gpio.sv ====
module wb_gpio (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_cyc,
  input  logic                      i_stb,
  input  logic                      i_we,
  input  logic [wb_pkg::SEL_W-1:0]  i_sel,
  input  logic [wb_pkg::ADDR_W-1:0] i_adr,
  input  logic [wb_pkg::DATA_W-1:0] i_dat,
  output logic                      o_ack,
  output logic [wb_pkg::DATA_W-1:0] o_dat,
  output logic                      o_int,
  input  logic [wb_pkg::GPIO_W-1:0] i_gpio_in,
  output logic [wb_pkg::GPIO_W-1:0] o_gpio_out
);
  import wb_pkg::*;

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] mask_q;
  logic [GPIO_W-1:0] status_q;
  logic [GPIO_W-1:0] sync_q1;
  logic [GPIO_W-1:0] sync_q2;
  logic [GPIO_W-1:0] in_prev;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] status_clr;
  logic              access;
  logic              wr;
  logic [1:0]        offset;

  assign access     = i_cyc & i_stb & ~o_ack;
  assign wr         = access & i_we & i_sel[0];  // All pins live in byte lane 0.
  assign offset     = i_adr[3:2];
  assign rise       = sync_q2 & ~in_prev;
  assign status_clr = (wr && (offset == GPIO_STATUS)) ? i_dat[GPIO_W-1:0] : '0;
  assign o_gpio_out = out_q;
  assign o_int      = |(status_q & mask_q);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ack    <= 1'b0;
      out_q    <= '0;
      mask_q   <= '0;
      status_q <= '0;
      sync_q1  <= '0;
      sync_q2  <= '0;
      in_prev  <= '0;
    end else begin
      o_ack   <= access;
      sync_q1 <= i_gpio_in;  // Pins are asynchronous to the bus clock.
      sync_q2 <= sync_q1;
      in_prev <= sync_q2;
      if (wr && (offset == GPIO_OUT)) begin
        out_q <= i_dat[GPIO_W-1:0];
      end
      if (wr && (offset == GPIO_MASK)) begin
        mask_q <= i_dat[GPIO_W-1:0];
      end
      status_q <= (status_q & ~status_clr) | rise;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (offset)
        GPIO_OUT:  o_dat <= {{(DATA_W-GPIO_W){1'b0}}, out_q};
        GPIO_IN:   o_dat <= {{(DATA_W-GPIO_W){1'b0}}, sync_q2};
        GPIO_MASK: o_dat <= {{(DATA_W-GPIO_W){1'b0}}, mask_q};
        default:   o_dat <= {{(DATA_W-GPIO_W){1'b0}}, status_q};
      endcase
    end
  end

endmodule

// ==== wb_subsystem_top.sv ====
module wb_subsystem_top (
  input  logic                      clk,
  input  logic                      i_arst_n,
  input  logic                      i_cmd_valid,
  input  wb_pkg::wb_op_e            i_cmd_op,
  input  logic [wb_pkg::ADDR_W-1:0] i_cmd_adr,
  input  logic [wb_pkg::SEL_W-1:0]  i_cmd_sel,
  input  logic [wb_pkg::DATA_W-1:0] i_cmd_dat,
  output logic                      o_cmd_credit,
  input  logic                      i_rsp_credit,
  output logic                      o_rsp_valid,
  output logic [wb_pkg::DATA_W-1:0] o_rsp_dat,
  output logic                      o_rsp_err,
  input  logic [wb_pkg::GPIO_W-1:0] i_gpio_in,
  output logic [wb_pkg::GPIO_W-1:0] o_gpio_out,
  output logic                      o_irq
);
  import wb_pkg::*;

  logic              m_cyc, m_stb, m_we, m_ack, m_err;
  logic [SEL_W-1:0]  m_sel;
  logic [ADDR_W-1:0] m_adr;
  logic [DATA_W-1:0] m_wdat, m_rdat;
  logic              s0_cyc, s0_stb, s0_we, s0_ack, s0_int;
  logic              s1_cyc, s1_stb, s1_we, s1_ack, s1_int;
  logic              s2_cyc, s2_stb, s2_we, s2_ack, s2_int;
  logic [SEL_W-1:0]  s0_sel, s1_sel, s2_sel;
  logic [ADDR_W-1:0] s0_adr, s1_adr, s2_adr;
  logic [DATA_W-1:0] s0_wdat, s1_wdat, s2_wdat;
  logic [DATA_W-1:0] s0_rdat, s1_rdat, s2_rdat;

  wb_host_bridge u_bridge (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_cmd_valid(i_cmd_valid), .i_cmd_op(i_cmd_op), .i_cmd_adr(i_cmd_adr),
    .i_cmd_sel(i_cmd_sel), .i_cmd_dat(i_cmd_dat), .o_cmd_credit(o_cmd_credit),
    .i_rsp_credit(i_rsp_credit), .o_rsp_valid(o_rsp_valid),
    .o_rsp_dat(o_rsp_dat), .o_rsp_err(o_rsp_err),
    .o_m_cyc(m_cyc), .o_m_stb(m_stb), .o_m_we(m_we), .o_m_sel(m_sel),
    .o_m_adr(m_adr), .o_m_dat(m_wdat),
    .i_m_ack(m_ack), .i_m_err(m_err), .i_m_dat(m_rdat)
  );

  wb_interconnect u_interconnect (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_m_cyc(m_cyc), .i_m_stb(m_stb), .i_m_we(m_we), .i_m_sel(m_sel),
    .i_m_adr(m_adr), .i_m_dat(m_wdat),
    .o_m_dat(m_rdat), .o_m_ack(m_ack), .o_m_err(m_err), .o_m_int(o_irq),
    .o_s0_cyc(s0_cyc), .o_s0_stb(s0_stb), .o_s0_we(s0_we), .o_s0_sel(s0_sel),
    .o_s0_adr(s0_adr), .o_s0_dat(s0_wdat),
    .i_s0_ack(s0_ack), .i_s0_int(s0_int), .i_s0_dat(s0_rdat),
    .o_s1_cyc(s1_cyc), .o_s1_stb(s1_stb), .o_s1_we(s1_we), .o_s1_sel(s1_sel),
    .o_s1_adr(s1_adr), .o_s1_dat(s1_wdat),
    .i_s1_ack(s1_ack), .i_s1_int(s1_int), .i_s1_dat(s1_rdat),
    .o_s2_cyc(s2_cyc), .o_s2_stb(s2_stb), .o_s2_we(s2_we), .o_s2_sel(s2_sel),
    .o_s2_adr(s2_adr), .o_s2_dat(s2_wdat),
    .i_s2_ack(s2_ack), .i_s2_int(s2_int), .i_s2_dat(s2_rdat)
  );

  wb_sram u_sram (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_cyc(s0_cyc), .i_stb(s0_stb), .i_we(s0_we), .i_sel(s0_sel),
    .i_adr(s0_adr), .i_dat(s0_wdat),
    .o_ack(s0_ack), .o_dat(s0_rdat), .o_int(s0_int)
  );

  wb_timer u_timer (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_cyc(s1_cyc), .i_stb(s1_stb), .i_we(s1_we), .i_sel(s1_sel),
    .i_adr(s1_adr), .i_dat(s1_wdat),
    .o_ack(s1_ack), .o_dat(s1_rdat), .o_int(s1_int)
  );

  wb_gpio u_gpio (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_cyc(s2_cyc), .i_stb(s2_stb), .i_we(s2_we), .i_sel(s2_sel),
    .i_adr(s2_adr), .i_dat(s2_wdat),
    .o_ack(s2_ack), .o_dat(s2_rdat), .o_int(s2_int),
    .i_gpio_in(i_gpio_in), .o_gpio_out(o_gpio_out)
  );

endmodule

// ==== wb_host_bridge_assert.sv ====
module wb_host_bridge_assert (
  input logic clk,
  input logic i_arst_n,
  input logic i_cyc,
  input logic i_stb,
  input logic i_ack,
  input logic i_err,
  input logic i_cmd_valid,
  input logic i_cmd_credit,
  input logic i_rsp_valid,
  input logic i_rsp_credit
);
  import wb_pkg::*;

  logic [$clog2(CMD_DEPTH+1)-1:0]   held_cmds;  // Commands sent and not yet credited back.
  logic [$clog2(RSP_CREDITS+1)-1:0] rsp_left;

  // The host ports alone give the queue fill and the response credits.
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      held_cmds <= '0;
      rsp_left  <= ($clog2(RSP_CREDITS+1))'(RSP_CREDITS);
    end else begin
      case ({i_cmd_valid, i_cmd_credit})
        2'b10:   held_cmds <= held_cmds + 1'b1;
        2'b01:   held_cmds <= held_cmds - 1'b1;
        default: held_cmds <= held_cmds;
      endcase
      case ({i_rsp_credit, i_rsp_valid})
        2'b10:   rsp_left <= rsp_left + 1'b1;
        2'b01:   rsp_left <= rsp_left - 1'b1;
        default: rsp_left <= rsp_left;
      endcase
    end
  end

  stb_needs_cyc: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_stb |-> i_cyc)
    else $error("Wishbone strobe seen without cycle.");

  // A strobe may only end after the slave has answered.
  stb_held: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_stb && !(i_ack || i_err)) |=> i_stb)
    else $error("Wishbone strobe dropped before ack or err.");

  rsp_has_credit: assert property (@(posedge clk) disable iff (!i_arst_n)
    $rose(i_rsp_valid) |-> (rsp_left != '0))
    else $error("Response issued with no response credit.");

  credit_needs_entry: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_cmd_credit |-> (held_cmds != '0))
    else $error("Command credit returned from an empty queue.");

endmodule

bind wb_host_bridge wb_host_bridge_assert u_bridge_assert (
  .clk(clk), .i_arst_n(i_arst_n),
  .i_cyc(o_m_cyc), .i_stb(o_m_stb), .i_ack(i_m_ack), .i_err(i_m_err),
  .i_cmd_valid(i_cmd_valid), .i_cmd_credit(o_cmd_credit),
  .i_rsp_valid(o_rsp_valid), .i_rsp_credit(i_rsp_credit)
);

// ==== tb_wb_subsystem.sv ====
module tb_wb_subsystem;
  import wb_pkg::*;

  localparam int TIMEOUT = 300;
  localparam int WINDOW  = 40;

  logic              clk;
  logic              i_arst_n;
  logic              i_cmd_valid;
  wb_op_e            i_cmd_op;
  logic [ADDR_W-1:0] i_cmd_adr;
  logic [SEL_W-1:0]  i_cmd_sel;
  logic [DATA_W-1:0] i_cmd_dat;
  logic              o_cmd_credit;
  logic              i_rsp_credit;
  logic              o_rsp_valid;
  logic [DATA_W-1:0] o_rsp_dat;
  logic              o_rsp_err;
  logic [GPIO_W-1:0] i_gpio_in;
  logic [GPIO_W-1:0] o_gpio_out;
  logic              o_irq;

  logic [DATA_W-1:0] rsp_dat_q[$];
  logic              rsp_err_q[$];
  int                cmd_credits;  // Host copy of the command credits.
  int                credits_seen;
  int                checks;
  int                errors;
  int                timeouts;

  wb_subsystem_top uut (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_cmd_valid(i_cmd_valid), .i_cmd_op(i_cmd_op), .i_cmd_adr(i_cmd_adr),
    .i_cmd_sel(i_cmd_sel), .i_cmd_dat(i_cmd_dat), .o_cmd_credit(o_cmd_credit),
    .i_rsp_credit(i_rsp_credit), .o_rsp_valid(o_rsp_valid),
    .o_rsp_dat(o_rsp_dat), .o_rsp_err(o_rsp_err),
    .i_gpio_in(i_gpio_in), .o_gpio_out(o_gpio_out), .o_irq(o_irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Responses and credit pulses are collected mid-cycle, where they are stable.
  always @(negedge clk) begin
    if (o_rsp_valid) begin
      rsp_dat_q.push_back(o_rsp_dat);
      rsp_err_q.push_back(o_rsp_err);
    end
    if (o_cmd_credit) begin
      cmd_credits++;
      credits_seen++;
    end
  end

  function automatic logic [ADDR_W-1:0] reg_addr(input logic [7:0] region,
                                                 input logic [1:0] word);
    return {region, 20'd0, word, 2'b00};
  endfunction

  function automatic logic [ADDR_W-1:0] sram_addr(input logic [7:0] idx);
    return {SLV_SRAM, 14'd0, idx, 2'b00};
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic observe(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(posedge clk);
    end
  endtask

  task automatic send_cmd(input wb_op_e op, input logic [ADDR_W-1:0] adr,
                          input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] dat);
    int n;
    n = 0;
    while (cmd_credits == 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (cmd_credits == 0) begin
      $display("Timeout: the bridge returned no command credit");
      timeouts++;
    end else begin
      @(posedge clk);
      i_cmd_valid <= 1'b1;
      i_cmd_op    <= op;
      i_cmd_adr   <= adr;
      i_cmd_sel   <= sel;
      i_cmd_dat   <= dat;
      cmd_credits--;
      @(posedge clk);
      i_cmd_valid <= 1'b0;
    end
  endtask

  task automatic wait_rsp(output logic [DATA_W-1:0] dat, output logic err);
    int n;
    n = 0;
    while (rsp_dat_q.size() == 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (rsp_dat_q.size() == 0) begin
      $display("Timeout: no response came back from the bridge");
      timeouts++;
      dat = 'x;
      err = 1'bx;
    end else begin
      dat = rsp_dat_q.pop_front();
      err = rsp_err_q.pop_front();
    end
  endtask

  task automatic give_rsp_credit();
    @(posedge clk);
    i_rsp_credit <= 1'b1;
    @(posedge clk);
    i_rsp_credit <= 1'b0;
  endtask

  task automatic access(input wb_op_e op, input logic [ADDR_W-1:0] adr,
                        input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] wdat,
                        output logic [DATA_W-1:0] rdat, output logic err);
    send_cmd(op, adr, sel, wdat);
    wait_rsp(rdat, err);
    give_rsp_credit();
  endtask

  task automatic wait_irq(input logic level, input string what);
    int n;
    n = 0;
    while (o_irq !== level && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (o_irq !== level) begin
      $display("Timeout: o_irq never reached %0d while %s", level, what);
      timeouts++;
    end
  endtask

  task automatic test_sram();
    logic [DATA_W-1:0] ref_mem [8];
    logic [DATA_W-1:0] wdat;
    logic [DATA_W-1:0] rdat;
    logic [SEL_W-1:0]  sel;
    logic              err;
    for (int i = 0; i < 8; i++) begin
      ref_mem[i] = $urandom();
      access(OP_WRITE, sram_addr(8'(i * 9 + 1)), 4'hF, ref_mem[i], rdat, err);
      check_word("o_rsp_err", {31'd0, err}, 32'd0);
    end
    wdat = $urandom();
    sel  = 4'b0101;
    access(OP_WRITE, sram_addr(8'd19), sel, wdat, rdat, err);  // Word 2 of the list.
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        ref_mem[2][8*b +: 8] = wdat[8*b +: 8];
      end
    end
    for (int i = 0; i < 8; i++) begin
      access(OP_READ, sram_addr(8'(i * 9 + 1)), 4'hF, 32'd0, rdat, err);
      check_word("o_rsp_dat", rdat, ref_mem[i]);
      check_word("o_rsp_err", {31'd0, err}, 32'd0);
    end
  endtask

  task automatic test_timer();
    logic [DATA_W-1:0] rdat;
    logic              err;
    access(OP_WRITE, reg_addr(SLV_TIMER, TMR_LOAD), 4'hF, 32'd40, rdat, err);
    access(OP_WRITE, reg_addr(SLV_TIMER, TMR_CTRL), 4'hF, 32'd3, rdat, err);
    wait_irq(1'b1, "the timer counts down");
    access(OP_READ, reg_addr(SLV_TIMER, TMR_STATUS), 4'hF, 32'd0, rdat, err);
    check_word("o_rsp_dat", rdat, 32'd1);
    access(OP_READ, reg_addr(SLV_IRQ, 2'd0), 4'hF, 32'd0, rdat, err);
    check_word("o_rsp_dat", rdat, 32'h2);
    check_word("o_rsp_err", {31'd0, err}, 32'd0);
    // Counting stops first so that no later expiry sets STATUS again.
    access(OP_WRITE, reg_addr(SLV_TIMER, TMR_CTRL), 4'hF, 32'd2, rdat, err);
    access(OP_WRITE, reg_addr(SLV_TIMER, TMR_STATUS), 4'hF, 32'd1, rdat, err);
    @(negedge clk);
    check_word("o_irq", {31'd0, o_irq}, 32'd0);
  endtask

  task automatic test_gpio();
    logic [DATA_W-1:0] rdat;
    logic              err;
    logic              seen_irq;
    access(OP_WRITE, reg_addr(SLV_GPIO, GPIO_OUT), 4'hF, 32'hA5, rdat, err);
    @(negedge clk);
    check_word("o_gpio_out", {24'd0, o_gpio_out}, 32'hA5);
    @(posedge clk);
    i_gpio_in <= 8'h3C;  // Rising edges while MASK is still clear.
    seen_irq = 1'b0;
    for (int n = 0; n < WINDOW; n++) begin
      @(negedge clk);
      seen_irq = seen_irq | o_irq;
    end
    check_word("o_irq", {31'd0, seen_irq}, 32'd0);
    access(OP_READ, reg_addr(SLV_GPIO, GPIO_IN), 4'hF, 32'd0, rdat, err);
    check_word("o_rsp_dat", rdat, 32'h3C);
    access(OP_READ, reg_addr(SLV_GPIO, GPIO_STATUS), 4'hF, 32'd0, rdat, err);
    check_word("o_rsp_dat", rdat, 32'h3C);
    access(OP_WRITE, reg_addr(SLV_GPIO, GPIO_STATUS), 4'hF, 32'hFF, rdat, err);
    access(OP_WRITE, reg_addr(SLV_GPIO, GPIO_MASK), 4'hF, 32'h01, rdat, err);
    @(posedge clk);
    i_gpio_in <= 8'h3D;
    wait_irq(1'b1, "GPIO pin 0 rises");
    access(OP_READ, reg_addr(SLV_GPIO, GPIO_STATUS), 4'hF, 32'd0, rdat, err);
    check_word("o_rsp_dat", rdat, 32'h01);
    access(OP_READ, reg_addr(SLV_IRQ, 2'd0), 4'hF, 32'd0, rdat, err);
    check_word("o_rsp_dat", rdat, 32'h4);
    access(OP_WRITE, reg_addr(SLV_GPIO, GPIO_STATUS), 4'hF, 32'h01, rdat, err);
    @(negedge clk);
    check_word("o_irq", {31'd0, o_irq}, 32'd0);
  endtask

  task automatic test_unmapped();
    logic [DATA_W-1:0] rdat;
    logic              err;
    access(OP_READ, {8'h05, 24'h000010}, 4'hF, 32'd0, rdat, err);
    check_word("o_rsp_err", {31'd0, err}, 32'd1);
    access(OP_WRITE, {8'h05, 24'h000010}, 4'hF, 32'hDEADBEEF, rdat, err);
    check_word("o_rsp_err", {31'd0, err}, 32'd1);
    observe(WINDOW);
    check_word("o_rsp_valid extra pulses", 32'(rsp_dat_q.size()), 32'd0);
    access(OP_WRITE, sram_addr(8'd200), 4'hF, 32'h1234ABCD, rdat, err);
    access(OP_READ, sram_addr(8'd200), 4'hF, 32'd0, rdat, err);
    check_word("o_rsp_dat", rdat, 32'h1234ABCD);
    check_word("o_rsp_err", {31'd0, err}, 32'd0);
  endtask

  task automatic test_backpressure();
    logic [DATA_W-1:0] exp_dat [CMD_DEPTH];
    logic [DATA_W-1:0] rdat;
    logic              err;
    int                base;
    for (int i = 0; i < CMD_DEPTH; i++) begin
      exp_dat[i] = $urandom();
      access(OP_WRITE, sram_addr(8'(100 + i)), 4'hF, exp_dat[i], rdat, err);
    end
    base = credits_seen;
    for (int i = 0; i < CMD_DEPTH; i++) begin
      send_cmd(OP_READ, sram_addr(8'(100 + i)), 4'hF, 32'd0);
    end
    observe(WINDOW);  // No response credits go back in this window.
    check_word("o_rsp_valid count", 32'(rsp_dat_q.size()), 32'(RSP_CREDITS));
    checks++;
    if (credits_seen - base > RSP_CREDITS) begin
      $display("Error: o_cmd_credit count 0x%0h, at most 0x%0h allowed",
               credits_seen - base, RSP_CREDITS);
      errors++;
    end
    for (int i = 0; i < CMD_DEPTH; i++) begin
      wait_rsp(rdat, err);
      check_word("o_rsp_dat", rdat, exp_dat[i]);
      check_word("o_rsp_err", {31'd0, err}, 32'd0);
      give_rsp_credit();
    end
  endtask

  initial begin
    void'($urandom(33));
    i_arst_n     = 1'b0;
    i_cmd_valid  = 1'b0;
    i_cmd_op     = OP_READ;
    i_cmd_adr    = '0;
    i_cmd_sel    = '0;
    i_cmd_dat    = '0;
    i_rsp_credit = 1'b0;
    i_gpio_in    = '0;
    cmd_credits  = CMD_DEPTH;
    credits_seen = 0;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    repeat (4) @(posedge clk);
    i_arst_n <= 1'b1;
    @(posedge clk);
    test_sram();
    test_timer();
    test_gpio();
    test_unmapped();
    test_backpressure();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
wb_pkg.sv
wb_interconnect.sv
wb_host_bridge.sv
wb_sram.sv
wb_timer.sv
wb_gpio.sv
wb_subsystem_top.sv
wb_host_bridge_assert.sv
tb_wb_subsystem.sv

// ==== Makefile ====
TOP := tb_wb_subsystem

.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f src.f -o $(TOP)_sim

run: build
	./obj_dir/$(TOP)_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
